// ==== src/prefix_defines.svh ====
/* x86 prefix decoder constants
   window size, byte width and the eleven legacy prefix byte codes */
`ifndef PREFIX_DEFINES_SVH
`define PREFIX_DEFINES_SVH

// number of instruction bytes examined in one window
`define PREFIX_WINDOW 4
// width of one instruction byte
`define BYTE_W 8

// group 1 holds the lock and repeat prefixes
`define PFX_LOCK     8'hF0
`define PFX_REPNE    8'hF2
`define PFX_REP      8'hF3
// group 2 holds the segment overrides
`define PFX_SEG_ES   8'h26
`define PFX_SEG_CS   8'h2E
`define PFX_SEG_SS   8'h36
`define PFX_SEG_DS   8'h3E
`define PFX_SEG_FS   8'h64
`define PFX_SEG_GS   8'h65
// group 3 is the operand size override and group 4 the address size override
`define PFX_OPSIZE   8'h66
`define PFX_ADDRSIZE 8'h67

`endif

// ==== src/prefix_pkg.sv ====
/* prefix decoder types
   segment register index, prefix run length and the per-group presence mask */
package prefix_pkg;

    // segment registers in the order the x86 sreg field encodes them
    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_index_e;

    // length of the leading prefix run, 0 up to the full window of 4
    // also wide enough to count how often one group occurs in a run
    typedef logic [2:0] prefix_count_t;

    // one bit per prefix group
    // bit 0 is group 1 (lock/rep), bit 1 is group 2 (segment),
    // bit 2 is group 3 (operand size) and bit 3 is group 4 (address size)
    typedef logic [3:0] group_mask_t;

endpackage

// ==== src/prefix_byte_decoder.sv ====
/* single byte prefix classifier
   tells whether one byte is a legacy prefix, which group it is in and what it means */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_byte_decoder
    import prefix_pkg::*;
(
    input  logic [`BYTE_W-1:0] i_byte,
    output logic               o_is_prefix,
    output group_mask_t        o_group,
    output logic               o_lock,
    output logic               o_repeat_not_equal,
    output logic               o_repeat_equal,
    output logic               o_segment_override,
    output logic               o_operand_size,
    output logic               o_address_size,
    output seg_index_e         o_segment_index
);

    always_comb begin
        // a byte that matches no prefix code leaves everything cleared
        o_group            = '0;
        o_lock             = 1'b0;
        o_repeat_not_equal = 1'b0;
        o_repeat_equal     = 1'b0;
        o_segment_override = 1'b0;
        o_operand_size     = 1'b0;
        o_address_size     = 1'b0;
        o_segment_index    = SEG_ES;
        case (i_byte)
            `PFX_LOCK: begin
                o_lock  = 1'b1;
                o_group = 4'b0001;
            end
            `PFX_REPNE: begin
                o_repeat_not_equal = 1'b1;
                o_group            = 4'b0001;
            end
            `PFX_REP: begin
                o_repeat_equal = 1'b1;
                o_group        = 4'b0001;
            end
            // all six segment overrides share group 2 and differ only in the index
            `PFX_SEG_ES, `PFX_SEG_CS, `PFX_SEG_SS,
            `PFX_SEG_DS, `PFX_SEG_FS, `PFX_SEG_GS: begin
                o_segment_override = 1'b1;
                o_group            = 4'b0010;
                case (i_byte)
                    `PFX_SEG_CS: o_segment_index = SEG_CS;
                    `PFX_SEG_SS: o_segment_index = SEG_SS;
                    `PFX_SEG_DS: o_segment_index = SEG_DS;
                    `PFX_SEG_FS: o_segment_index = SEG_FS;
                    `PFX_SEG_GS: o_segment_index = SEG_GS;
                    default:     o_segment_index = SEG_ES;
                endcase
            end
            `PFX_OPSIZE: begin
                o_operand_size = 1'b1;
                o_group        = 4'b0100;
            end
            `PFX_ADDRSIZE: begin
                o_address_size = 1'b1;
                o_group        = 4'b1000;
            end
            default: begin
                o_group = '0;
            end
        endcase
    end

    // every prefix sets exactly one group bit, so any set bit marks a prefix
    assign o_is_prefix = |o_group;

endmodule

// ==== src/prefix_fetch_stage.sv ====
/* prefix decoder input stage
   captures the instruction window on a valid strobe and classifies each held byte */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_fetch_stage
    import prefix_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_valid,
    input  logic [`BYTE_W-1:0] i_instruction      [0:`PREFIX_WINDOW-1],
    output logic               o_valid,
    output logic               o_is_prefix        [0:`PREFIX_WINDOW-1],
    output group_mask_t        o_group            [0:`PREFIX_WINDOW-1],
    output logic               o_lock             [0:`PREFIX_WINDOW-1],
    output logic               o_repeat_not_equal [0:`PREFIX_WINDOW-1],
    output logic               o_repeat_equal     [0:`PREFIX_WINDOW-1],
    output logic               o_segment_override [0:`PREFIX_WINDOW-1],
    output logic               o_operand_size     [0:`PREFIX_WINDOW-1],
    output logic               o_address_size     [0:`PREFIX_WINDOW-1],
    output seg_index_e         o_segment_index    [0:`PREFIX_WINDOW-1]
);

    // held copy of the last window that arrived with a strobe
    logic [`BYTE_W-1:0] window_q [0:`PREFIX_WINDOW-1];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            for (int i = 0; i < `PREFIX_WINDOW; i++) begin
                window_q[i] <= '0;
            end
        end else begin
            // the valid bit follows the strobe every cycle so it forms a one cycle pulse
            o_valid <= i_valid;
            if (i_valid) begin
                window_q <= i_instruction;
            end
        end
    end

    // one decoder per byte position, all working in parallel on the held window
    for (genvar b = 0; b < `PREFIX_WINDOW; b++) begin : g_byte
        prefix_byte_decoder u_byte_decoder (
            .i_byte             (window_q[b]),
            .o_is_prefix        (o_is_prefix[b]),
            .o_group            (o_group[b]),
            .o_lock             (o_lock[b]),
            .o_repeat_not_equal (o_repeat_not_equal[b]),
            .o_repeat_equal     (o_repeat_equal[b]),
            .o_segment_override (o_segment_override[b]),
            .o_operand_size     (o_operand_size[b]),
            .o_address_size     (o_address_size[b]),
            .o_segment_index    (o_segment_index[b])
        );
    end

endmodule

// ==== src/prefix_merge.sv ====
/* prefix run merge logic
   walks the leading prefix run, ORs its meanings, counts its bytes and flags repeated groups */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_merge
    import prefix_pkg::*;
(
    input  logic          i_is_prefix        [0:`PREFIX_WINDOW-1],
    input  group_mask_t   i_group            [0:`PREFIX_WINDOW-1],
    input  logic          i_lock             [0:`PREFIX_WINDOW-1],
    input  logic          i_repeat_not_equal [0:`PREFIX_WINDOW-1],
    input  logic          i_repeat_equal     [0:`PREFIX_WINDOW-1],
    input  logic          i_segment_override [0:`PREFIX_WINDOW-1],
    input  logic          i_operand_size     [0:`PREFIX_WINDOW-1],
    input  logic          i_address_size     [0:`PREFIX_WINDOW-1],
    input  seg_index_e    i_segment_index    [0:`PREFIX_WINDOW-1],
    output logic          o_lock,
    output logic          o_repeat_not_equal,
    output logic          o_repeat_equal,
    output logic          o_segment_override,
    output logic          o_operand_size,
    output logic          o_address_size,
    output seg_index_e    o_segment_index,
    output prefix_count_t o_prefix_count,
    output logic          o_error
);

    // how many bytes of each group sit inside the leading run
    prefix_count_t group_count [0:3];

    always_comb begin : merge_run
        logic run_open;
        logic seg_found;
        // the run starts open and closes for good at the first non-prefix byte
        run_open           = 1'b1;
        seg_found          = 1'b0;
        o_lock             = 1'b0;
        o_repeat_not_equal = 1'b0;
        o_repeat_equal     = 1'b0;
        o_segment_override = 1'b0;
        o_operand_size     = 1'b0;
        o_address_size     = 1'b0;
        o_segment_index    = SEG_ES;
        o_prefix_count     = '0;
        for (int g = 0; g < 4; g++) begin
            group_count[g] = '0;
        end
        for (int i = 0; i < `PREFIX_WINDOW; i++) begin
            run_open = run_open & i_is_prefix[i];
            // bytes after the run belong to the opcode and take no part
            if (run_open) begin
                o_prefix_count     = o_prefix_count + 1'b1;
                o_lock             = o_lock | i_lock[i];
                o_repeat_not_equal = o_repeat_not_equal | i_repeat_not_equal[i];
                o_repeat_equal     = o_repeat_equal | i_repeat_equal[i];
                o_segment_override = o_segment_override | i_segment_override[i];
                o_operand_size     = o_operand_size | i_operand_size[i];
                o_address_size     = o_address_size | i_address_size[i];
                // the first override in the run names the segment
                if (i_segment_override[i] && !seg_found) begin
                    o_segment_index = i_segment_index[i];
                    seg_found       = 1'b1;
                end
                for (int g = 0; g < 4; g++) begin
                    group_count[g] = group_count[g] + i_group[i][g];
                end
            end
        end
        // a group used more than once within the run is an encoding error
        o_error = 1'b0;
        for (int g = 0; g < 4; g++) begin
            if (group_count[g] > 3'd1) begin
                o_error = 1'b1;
            end
        end
    end

endmodule

// ==== src/prefix_result_stage.sv ====
/* prefix decoder output stage
   holds the merged result of each window and issues its valid pulse */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_result_stage
    import prefix_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_valid,
    input  logic          i_lock,
    input  logic          i_repeat_not_equal,
    input  logic          i_repeat_equal,
    input  logic          i_segment_override,
    input  logic          i_operand_size,
    input  logic          i_address_size,
    input  seg_index_e    i_segment_index,
    input  prefix_count_t i_prefix_count,
    input  logic          i_error,
    output logic          o_valid,
    output logic          o_lock,
    output logic          o_repeat_not_equal,
    output logic          o_repeat_equal,
    output logic          o_segment_override,
    output logic          o_operand_size,
    output logic          o_address_size,
    output seg_index_e    o_segment_index,
    output prefix_count_t o_prefix_count,
    output logic          o_error
);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid            <= 1'b0;
            o_lock             <= 1'b0;
            o_repeat_not_equal <= 1'b0;
            o_repeat_equal     <= 1'b0;
            o_segment_override <= 1'b0;
            o_operand_size     <= 1'b0;
            o_address_size     <= 1'b0;
            o_segment_index    <= SEG_ES;
            o_prefix_count     <= '0;
            o_error            <= 1'b0;
        end else begin
            o_valid <= i_valid;
            // the result only moves with a window, so it holds while the output is idle
            if (i_valid) begin
                o_lock             <= i_lock;
                o_repeat_not_equal <= i_repeat_not_equal;
                o_repeat_equal     <= i_repeat_equal;
                o_segment_override <= i_segment_override;
                o_operand_size     <= i_operand_size;
                o_address_size     <= i_address_size;
                o_segment_index    <= i_segment_index;
                o_prefix_count     <= i_prefix_count;
                o_error            <= i_error;
            end
        end
    end

    // the run walk in the merge logic can never count past the window
    a_count_in_window: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_prefix_count <= `PREFIX_WINDOW);

    // an empty run holds no prefix that could set a flag or repeat a group
    a_empty_run_clear: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_prefix_count == '0) |-> !(o_lock || o_repeat_not_equal || o_repeat_equal ||
                                     o_segment_override || o_operand_size ||
                                     o_address_size || o_error));

    // REPNE and REP share group 1, so seeing both in one run must raise the error
    a_rep_conflict: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_repeat_not_equal && o_repeat_equal) |-> o_error);

endmodule

// ==== src/prefix_decode_top.sv ====
/* x86 legacy prefix decoder
   two stage pipeline from instruction window to merged prefix flags, count and error */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_decode_top
    import prefix_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_valid,
    input  logic [`BYTE_W-1:0] i_instruction [0:`PREFIX_WINDOW-1],
    output logic               o_valid,
    output logic               o_lock,
    output logic               o_repeat_not_equal,
    output logic               o_repeat_equal,
    output logic               o_segment_override,
    output seg_index_e         o_segment_index,
    output logic               o_operand_size,
    output logic               o_address_size,
    output prefix_count_t      o_prefix_count,
    output logic               o_error
);

    // per-byte classification of the held window
    logic          fetch_valid;
    logic          byte_is_prefix        [0:`PREFIX_WINDOW-1];
    group_mask_t   byte_group            [0:`PREFIX_WINDOW-1];
    logic          byte_lock             [0:`PREFIX_WINDOW-1];
    logic          byte_repeat_not_equal [0:`PREFIX_WINDOW-1];
    logic          byte_repeat_equal     [0:`PREFIX_WINDOW-1];
    logic          byte_segment_override [0:`PREFIX_WINDOW-1];
    logic          byte_operand_size     [0:`PREFIX_WINDOW-1];
    logic          byte_address_size     [0:`PREFIX_WINDOW-1];
    seg_index_e    byte_segment_index    [0:`PREFIX_WINDOW-1];

    // merged result before the output register
    logic          merge_lock;
    logic          merge_repeat_not_equal;
    logic          merge_repeat_equal;
    logic          merge_segment_override;
    logic          merge_operand_size;
    logic          merge_address_size;
    seg_index_e    merge_segment_index;
    prefix_count_t merge_prefix_count;
    logic          merge_error;

    prefix_fetch_stage u_fetch (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_valid            (i_valid),
        .i_instruction      (i_instruction),
        .o_valid            (fetch_valid),
        .o_is_prefix        (byte_is_prefix),
        .o_group            (byte_group),
        .o_lock             (byte_lock),
        .o_repeat_not_equal (byte_repeat_not_equal),
        .o_repeat_equal     (byte_repeat_equal),
        .o_segment_override (byte_segment_override),
        .o_operand_size     (byte_operand_size),
        .o_address_size     (byte_address_size),
        .o_segment_index    (byte_segment_index)
    );

    prefix_merge u_merge (
        .i_is_prefix        (byte_is_prefix),
        .i_group            (byte_group),
        .i_lock             (byte_lock),
        .i_repeat_not_equal (byte_repeat_not_equal),
        .i_repeat_equal     (byte_repeat_equal),
        .i_segment_override (byte_segment_override),
        .i_operand_size     (byte_operand_size),
        .i_address_size     (byte_address_size),
        .i_segment_index    (byte_segment_index),
        .o_lock             (merge_lock),
        .o_repeat_not_equal (merge_repeat_not_equal),
        .o_repeat_equal     (merge_repeat_equal),
        .o_segment_override (merge_segment_override),
        .o_operand_size     (merge_operand_size),
        .o_address_size     (merge_address_size),
        .o_segment_index    (merge_segment_index),
        .o_prefix_count     (merge_prefix_count),
        .o_error            (merge_error)
    );

    prefix_result_stage u_result (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_valid            (fetch_valid),
        .i_lock             (merge_lock),
        .i_repeat_not_equal (merge_repeat_not_equal),
        .i_repeat_equal     (merge_repeat_equal),
        .i_segment_override (merge_segment_override),
        .i_operand_size     (merge_operand_size),
        .i_address_size     (merge_address_size),
        .i_segment_index    (merge_segment_index),
        .i_prefix_count     (merge_prefix_count),
        .i_error            (merge_error),
        .o_valid            (o_valid),
        .o_lock             (o_lock),
        .o_repeat_not_equal (o_repeat_not_equal),
        .o_repeat_equal     (o_repeat_equal),
        .o_segment_override (o_segment_override),
        .o_operand_size     (o_operand_size),
        .o_address_size     (o_address_size),
        .o_segment_index    (o_segment_index),
        .o_prefix_count     (o_prefix_count),
        .o_error            (o_error)
    );

endmodule

// ==== testbench/prefix_decode_tb.sv ====
/* testbench for the x86 prefix decoder
   replays windows from the test file and checks every result pulse against it */
`timescale 1ns/10ps
`include "prefix_defines.svh"

module prefix_decode_tb
    import prefix_pkg::*;
();

    localparam int MAX_TESTS = 64;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_valid;
    logic [`BYTE_W-1:0] i_instruction [0:`PREFIX_WINDOW-1];
    logic               o_valid;
    logic               o_lock;
    logic               o_repeat_not_equal;
    logic               o_repeat_equal;
    logic               o_segment_override;
    seg_index_e         o_segment_index;
    logic               o_operand_size;
    logic               o_address_size;
    prefix_count_t      o_prefix_count;
    logic               o_error;

    // test table as read from the data file
    logic [8*24-1:0]    test_name  [0:MAX_TESTS-1];
    logic [`BYTE_W-1:0] test_bytes [0:MAX_TESTS-1][0:`PREFIX_WINDOW-1];
    logic [5:0]         test_flags [0:MAX_TESTS-1];
    logic [2:0]         test_index [0:MAX_TESTS-1];
    logic [2:0]         test_count [0:MAX_TESTS-1];
    logic               test_error [0:MAX_TESTS-1];

    // windows in flight, with the clock edge count at the moment each was driven
    int     issue_q[$];
    int     issue_edge_q[$];
    int     num_tests  = 0;
    int     checked    = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     edge_count = 0;
    bit     loaded     = 1'b0;
    integer seed       = 74;

    prefix_decode_top DUT (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_valid            (i_valid),
        .i_instruction      (i_instruction),
        .o_valid            (o_valid),
        .o_lock             (o_lock),
        .o_repeat_not_equal (o_repeat_not_equal),
        .o_repeat_equal     (o_repeat_equal),
        .o_segment_override (o_segment_override),
        .o_segment_index    (o_segment_index),
        .o_operand_size     (o_operand_size),
        .o_address_size     (o_address_size),
        .o_prefix_count     (o_prefix_count),
        .o_error            (o_error)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #5 i_clk = ~i_clk;
        end
    end

    // latency is measured in rising edges between drive and check
    always @(posedge i_clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic load_tests();
        int              fd;
        int              code;
        int              fields;
        string           line;
        logic [8*24-1:0] name;
        logic [7:0]      b0, b1, b2, b3;
        logic [5:0]      flags;
        logic [2:0]      idx;
        logic [2:0]      cnt;
        logic            err;
        fd = $fopen("testbench/prefix_tests.dat", "r");
        if (fd == 0) begin
            $display("could not open the test file testbench/prefix_tests.dat");
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // blank lines and lines starting with a hash carry no test
            if (code != 0 && line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                                 name, b0, b1, b2, b3, flags, idx, cnt, err);
                if (fields != 9 || num_tests >= MAX_TESTS) begin
                    $display("test file line could not be used: %s", line);
                    fail_count++;
                end else begin
                    test_name[num_tests]     = name;
                    test_bytes[num_tests][0] = b0;
                    test_bytes[num_tests][1] = b1;
                    test_bytes[num_tests][2] = b2;
                    test_bytes[num_tests][3] = b3;
                    test_flags[num_tests]    = flags;
                    test_index[num_tests]    = idx;
                    test_count[num_tests]    = cnt;
                    test_error[num_tests]    = err;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // the outputs must stay cleared between reset and the first strobe
    task automatic check_idle();
        logic [13:0] got;
        @(negedge i_clk);
        got = {o_valid, o_lock, o_repeat_not_equal, o_repeat_equal, o_segment_override,
               o_operand_size, o_address_size, o_segment_index, o_prefix_count, o_error};
        if (got !== 14'h0) begin
            $display("error idle_after_reset expected %h actual %h", 14'h0, got);
            fail_count++;
        end else begin
            $display("ok    idle_after_reset");
            pass_count++;
        end
    endtask

    task automatic drive_window(input int t);
        i_valid <= 1'b1;
        for (int i = 0; i < `PREFIX_WINDOW; i++) begin
            i_instruction[i] <= test_bytes[t][i];
        end
        issue_q.push_back(t);
        issue_edge_q.push_back(edge_count);
    endtask

    task automatic check_result();
        int         t;
        int         issued;
        logic [5:0] got_flags;
        bit         ok;
        string      field;
        logic [7:0] exp_val;
        logic [7:0] got_val;
        if (issue_q.size() == 0) begin
            $display("o_valid pulsed at %0t with no window outstanding", $time);
            fail_count++;
            return;
        end
        t         = issue_q.pop_front();
        issued    = issue_edge_q.pop_front();
        got_flags = {o_lock, o_repeat_not_equal, o_repeat_equal, o_segment_override,
                     o_operand_size, o_address_size};
        ok        = 1'b1;
        if (edge_count != issued + 3) begin
            $display("result of %0s arrived after %0d cycles instead of 2",
                     test_name[t], edge_count - issued - 1);
            ok = 1'b0;
        end
        // only the first wrong field of a test is reported
        if (ok && got_flags !== test_flags[t]) begin
            field   = "flags";
            exp_val = {2'b0, test_flags[t]};
            got_val = {2'b0, got_flags};
            ok      = 1'b0;
        end
        if (ok && o_prefix_count !== test_count[t]) begin
            field   = "count";
            exp_val = {5'b0, test_count[t]};
            got_val = {5'b0, o_prefix_count};
            ok      = 1'b0;
        end
        if (ok && o_error !== test_error[t]) begin
            field   = "error_bit";
            exp_val = {7'b0, test_error[t]};
            got_val = {7'b0, o_error};
            ok      = 1'b0;
        end
        // the index means something only for a clean run with an override
        if (ok && test_flags[t][2] && !test_error[t] && o_segment_index !== test_index[t]) begin
            field   = "index";
            exp_val = {5'b0, test_index[t]};
            got_val = {5'b0, o_segment_index};
            ok      = 1'b0;
        end
        if (ok) begin
            $display("ok    %0s", test_name[t]);
            pass_count++;
        end else begin
            if (field.len() > 0) begin
                $display("error %0s %0s expected %h actual %h",
                         test_name[t], field, exp_val, got_val);
            end
            fail_count++;
        end
        checked++;
    endtask

    always @(negedge i_clk) begin
        if (i_arst_n && o_valid) begin
            check_result();
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (num_tests * 2 + 20) @(posedge i_clk);
        $display("timeout with %0d of %0d results missing", num_tests - checked, num_tests);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        for (int i = 0; i < `PREFIX_WINDOW; i++) begin
            i_instruction[i] = '0;
        end
        load_tests();
        loaded = 1'b1;
        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;
        check_idle();
        for (int t = 0; t < num_tests; t++) begin
            @(posedge i_clk);
            // now and then leave a gap, which must not produce a pulse
            if (($random(seed) & 3) == 0) begin
                i_valid <= 1'b0;
                @(posedge i_clk);
            end
            drive_window(t);
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        while (checked < num_tests) begin
            @(negedge i_clk);
        end
        $display("%0d tests, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && num_tests > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/prefix_tests.dat ====
# name  byte0 byte1 byte2 byte3  flags  index  count  error   (bytes, flags and index in hex)
# flags bits from msb: lock repne rep seg_override opsize addrsize; byte0 comes first
no_prefix            90 90 90 90  00 0 0 0
opcode_then_prefixes 0F F0 66 2E  00 0 0 0
lock_only            F0 90 00 00  20 0 1 0
repne_only           F2 A6 00 00  10 0 1 0
rep_only             F3 A4 00 00  08 0 1 0
seg_es               26 8B 00 00  04 0 1 0
seg_cs               2E 8B 00 00  04 1 1 0
seg_ss               36 8B 00 00  04 2 1 0
seg_ds               3E 8B 00 00  04 3 1 0
seg_fs               64 8B 00 00  04 4 1 0
seg_gs               65 8B 00 00  04 5 1 0
opsize_only          66 90 00 00  02 0 1 0
addrsize_only        67 8B 00 00  01 0 1 0
opsize_addrsize      66 67 8B 00  03 0 2 0
lock_seg_fs          F0 64 89 00  24 4 2 0
four_groups_rep      F3 2E 66 67  0F 1 4 0
four_groups_lock     65 F0 67 66  27 5 4 0
three_then_opcode    3E 66 F2 AF  16 3 3 0
rep_conflict         F2 F3 A6 00  18 0 2 1
seg_repeat           2E 36 8B 00  04 1 2 1
opsize_repeat        66 66 90 00  02 0 2 1
addrsize_repeat_all  67 67 67 67  01 0 4 1
lock_repeat          F0 F0 90 00  20 0 2 1
lock_rep_two_segs    F0 F3 26 2E  2C 0 4 1
split_rep            F2 90 F3 00  10 0 1 0
split_seg            2E 8B 36 00  04 1 1 0
split_opsize         66 90 66 00  02 0 1 0

// ==== compile.f ====
+incdir+src
src/prefix_pkg.sv
src/prefix_byte_decoder.sv
src/prefix_fetch_stage.sv
src/prefix_merge.sv
src/prefix_result_stage.sv
src/prefix_decode_top.sv
testbench/prefix_decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the x86 prefix decoder testbench
SIM = obj_dir/Vprefix_decode_tb

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): compile.f $(wildcard src/*.sv src/*.svh testbench/*.sv)
	verilator --binary --assert -Wno-fatal -f compile.f --top-module prefix_decode_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
